// ==== design/boardControl.sv ====
// Board reset and interrupt keys
`timescale 1ns/1ps

module boardControl
(
    input  logic pll_clk,
    input  logic reset,
    input  logic pllLocked,
    // Keys are active low
    input  logic resetKey,
    input  logic intKey,
    input  logic nmiKey,
    output logic hostReset,
    output logic intRequest,
    output logic nmiRequest
);

    // Key synchronizers, idle level is high
    logic [1:0] intSync;
    // Two sync stages plus one stage for edge detect
    logic [2:0] nmiSync;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Board reset
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Any source holds the board in reset
    always_ff @(posedge pll_clk)
    begin
        hostReset <= reset | ~pllLocked | ~resetKey;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Interrupt keys
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Keys are asynchronous to pll_clk
    always_ff @(posedge pll_clk)
    begin
        if (hostReset)
        begin
            intSync    <= 2'b11;
            nmiSync    <= 3'b111;
            nmiRequest <= 1'b0;
        end
        else
        begin
            intSync <= {intSync[0], intKey};
            nmiSync <= {nmiSync[1:0], nmiKey};
            // NMI is edge triggered, one pulse per press
            nmiRequest <= nmiSync[2] & ~nmiSync[1];
        end
    end

    // INT is level triggered, held as long as the key is down
    assign intRequest = ~intSync[1];

endmodule

// ==== design/cpuClockDivider.sv ====
// CPU clock divider
`timescale 1ns/1ps

module cpuClockDivider
#(
    // Power of two, at least 2
    parameter int CpuClockDivide = 4
)
(
    input  logic pll_clk,
    input  logic hostReset,
    output logic cpuClk,
    output logic cpuTick
);

    // Toggle point is half the divide period
    localparam int HalfPeriod = CpuClockDivide / 2;
    localparam int CountWidth = (HalfPeriod > 1) ? $clog2(HalfPeriod) : 1;

    logic [CountWidth-1:0] divCount;
    logic                  halfDone;

    // Last count of each half period
    assign halfDone = (divCount == CountWidth'(HalfPeriod - 1));

    // Free-running counter, cpuClk starts low out of reset
    always_ff @(posedge pll_clk)
    begin
        if (hostReset)
        begin
            divCount <= '0;
            cpuClk   <= 1'b0;
            cpuTick  <= 1'b0;
        end
        else
        begin
            divCount <= halfDone ? '0 : divCount + 1'b1;
            if (halfDone)
                cpuClk <= ~cpuClk;
            // Tick lines up with the cycle in which cpuClk goes high
            cpuTick <= halfDone & ~cpuClk;
        end
    end

endmodule

// ==== design/hostBoard.sv ====
// Host board top level
`timescale 1ns/1ps

module hostBoard
#(
    parameter int             CpuClockDivide = 4,
    parameter int             BaudDivide     = 8,
    parameter hostPkg::data_t IntVector      = 8'h80
)
(
    input  logic             pll_clk,
    input  logic             reset,
    input  logic             pllLocked,
    // Keys, active low
    input  logic             resetKey,
    input  logic             intKey,
    input  logic             nmiKey,
    // CPU bus cycle, one pll_clk strobe each
    input  logic             busStrobe,
    input  hostPkg::cpuBus_t bus,
    output hostPkg::data_t   readData,
    output logic             readValid,
    // To the CPU core
    output logic             cpuClk,
    output logic             intRequest,
    output logic             nmiRequest,
    // Serial out
    output logic             uartTxd
);

    import hostPkg::*;

    // Board reset to every block
    logic     hostReset;

    // Decoder to RAM
    ramAddr_t ramAddr;
    data_t    ramWriteData;
    logic     ramWrite;
    data_t    ramReadData;

    // Decoder to UART
    logic     uartWrite;
    data_t    uartData;
    logic     uartBusy;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Clock and reset
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    boardControl boardControl_i (
        .pll_clk    (pll_clk),
        .reset      (reset),
        .pllLocked  (pllLocked),
        .resetKey   (resetKey),
        .intKey     (intKey),
        .nmiKey     (nmiKey),
        .hostReset  (hostReset),
        .intRequest (intRequest),
        .nmiRequest (nmiRequest)
    );

    // Tick output is for a clock-enabled core, none fitted yet
    cpuClockDivider #(
        .CpuClockDivide (CpuClockDivide)
    ) cpuClockDivider_i (
        .pll_clk   (pll_clk),
        .hostReset (hostReset),
        .cpuClk    (cpuClk),
        .cpuTick   ()
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decoder, RAM and UART
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    hostBusDecoder #(
        .IntVector (IntVector)
    ) hostBusDecoder_i (
        .pll_clk      (pll_clk),
        .hostReset    (hostReset),
        .busStrobe    (busStrobe),
        .bus          (bus),
        .ramReadData  (ramReadData),
        .uartBusy     (uartBusy),
        .ramAddr      (ramAddr),
        .ramWriteData (ramWriteData),
        .ramWrite     (ramWrite),
        .uartWrite    (uartWrite),
        .uartData     (uartData),
        .readData     (readData),
        .readValid    (readValid)
    );

    hostRam hostRam_i (
        .pll_clk      (pll_clk),
        .ramAddr      (ramAddr),
        .ramWriteData (ramWriteData),
        .ramWrite     (ramWrite),
        .ramReadData  (ramReadData)
    );

    uartIo #(
        .BaudDivide (BaudDivide)
    ) uartIo_i (
        .pll_clk   (pll_clk),
        .hostReset (hostReset),
        .uartWrite (uartWrite),
        .uartData  (uartData),
        .uartBusy  (uartBusy),
        .uartTxd   (uartTxd)
    );

endmodule

// ==== design/hostBusDecoder.sv ====
// Memory and IO decoder
`timescale 1ns/1ps

module hostBusDecoder
#(
    // Returned on any unassigned IO read, also serves as the IM2 vector
    parameter hostPkg::data_t IntVector = 8'h80
)
(
    input  logic              pll_clk,
    input  logic              hostReset,
    input  logic              busStrobe,
    input  hostPkg::cpuBus_t  bus,
    input  hostPkg::data_t    ramReadData,
    input  logic              uartBusy,
    output hostPkg::ramAddr_t ramAddr,
    output hostPkg::data_t    ramWriteData,
    output logic              ramWrite,
    output logic              uartWrite,
    output hostPkg::data_t    uartData,
    output hostPkg::data_t    readData,
    output logic              readValid
);

    import hostPkg::*;

    // Cycle classification
    logic  memCycle;
    logic  ioCycle;
    logic  isRead;
    logic  isWrite;
    logic  inRamRegion;
    data_t ioPort;
    logic  readCycle;

    // Read value known at strobe time
    data_t readImmediate;

    // Registered read selection
    logic  readFromRam;
    data_t readHold;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Cycle decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Memory request wins if both are set
    assign memCycle    = busStrobe & bus.mreq;
    assign ioCycle     = busStrobe & bus.iorq & ~bus.mreq;
    // Write wins if both directions are set
    assign isWrite     = bus.wr;
    assign isRead      = bus.rd & ~bus.wr;
    assign inRamRegion = (bus.addr[15:14] == RamRegionTag);
    // IO port number sits on the upper address byte
    assign ioPort      = bus.addr[15:8];
    assign readCycle   = (memCycle | ioCycle) & isRead;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // RAM sees the address on every cycle so reads start at the strobe
    assign ramAddr      = bus.addr[13:0];
    assign ramWriteData = bus.writeData;
    assign ramWrite     = memCycle & isWrite & inRamRegion;

    // Single-cycle strobe to the UART data port
    assign uartData  = bus.writeData;
    assign uartWrite = ioCycle & isWrite & (ioPort == UartDataPort);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Everything that is not RAM data
    always_comb
    begin
        if (memCycle)
            readImmediate = HaltOpcode;
        else if (ioPort == UartStatusPort)
            readImmediate = {{($bits(data_t) - 1){1'b0}}, uartBusy};
        else
            readImmediate = IntVector;
    end

    always_ff @(posedge pll_clk)
    begin
        if (hostReset)
        begin
            readValid   <= 1'b0;
            readFromRam <= 1'b0;
        end
        else
        begin
            readValid   <= readCycle;
            readFromRam <= readCycle & memCycle & inRamRegion;
        end
    end

    // Payload only, qualified by readValid
    always_ff @(posedge pll_clk)
    begin
        if (readCycle)
            readHold <= readImmediate;
    end

    // RAM data arrives in the same cycle as readValid
    assign readData = readFromRam ? ramReadData : readHold;

endmodule

// ==== design/hostPkg.sv ====
// Host board shared definitions
package hostPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // CPU address bus
    typedef logic [15:0] addr_t;
    // CPU data byte
    typedef logic [7:0] data_t;
    // RAM word address, 16 K deep
    typedef logic [13:0] ramAddr_t;

    // One CPU bus cycle, control bits active high
    typedef struct packed {
        addr_t addr;
        data_t writeData;
        logic  mreq;
        logic  iorq;
        logic  rd;
        logic  wr;
    } cpuBus_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory and IO map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Address bits 15:14 for the 16 KB RAM at 0000-3FFF
    localparam logic [1:0] RamRegionTag = 2'b00;
    // Unmapped memory reads as HALT so a runaway CPU stops
    localparam data_t HaltOpcode = 8'h76;
    // IO ports come from address bits 15:8
    localparam data_t UartDataPort = 8'h00;
    // Busy flag sits in bit 0 of this port
    localparam data_t UartStatusPort = 8'h02;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // UART transmitter states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        TxIdle,
        TxStart,
        TxData,
        TxStop
    } uartState_t;

endpackage

// ==== design/hostRam.sv ====
// Host RAM, 16 KB
`timescale 1ns/1ps

module hostRam
(
    input  logic              pll_clk,
    input  hostPkg::ramAddr_t ramAddr,
    input  hostPkg::data_t    ramWriteData,
    input  logic              ramWrite,
    output hostPkg::data_t    ramReadData
);

    import hostPkg::*;

    // One entry per RAM address
    localparam int RamDepth = 2 ** $bits(ramAddr_t);

    // Maps onto a block RAM
    data_t memArray [RamDepth];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Single port access
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Synchronous write
    always_ff @(posedge pll_clk)
    begin
        if (ramWrite)
            memArray[ramAddr] <= ramWriteData;
    end

    // Registered read, old data on a same-cycle write
    always_ff @(posedge pll_clk)
    begin
        ramReadData <= memArray[ramAddr];
    end

endmodule

// ==== design/uartIo.sv ====
// UART transmit port
`timescale 1ns/1ps

module uartIo
#(
    // pll_clk cycles per serial bit
    parameter int BaudDivide = 8
)
(
    input  logic           pll_clk,
    input  logic           hostReset,
    input  logic           uartWrite,
    input  hostPkg::data_t uartData,
    output logic           uartBusy,
    output logic           uartTxd
);

    import hostPkg::*;

    localparam int BaudWidth = (BaudDivide > 1) ? $clog2(BaudDivide) : 1;

    uartState_t           txState;
    logic [BaudWidth-1:0] baudCount;
    logic [2:0]           bitCount;
    // Bits still to go out, LSB next
    data_t                shiftReg;
    logic                 baudDone;

    // Last cycle of the current bit
    assign baudDone = (baudCount == BaudWidth'(BaudDivide - 1));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // 8N1 transmitter FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge pll_clk)
    begin
        if (hostReset)
        begin
            txState   <= TxIdle;
            baudCount <= '0;
            bitCount  <= '0;
            // Line idles high
            uartTxd   <= 1'b1;
        end
        else
        begin
            // Count through every bit, cleared at each bit boundary
            if (txState == TxIdle || baudDone)
                baudCount <= '0;
            else
                baudCount <= baudCount + 1'b1;

            case (txState)
                TxIdle:
                begin
                    // Writes only land here, so a write while busy is lost
                    if (uartWrite)
                    begin
                        txState <= TxStart;
                        uartTxd <= 1'b0;
                    end
                end
                TxStart:
                begin
                    if (baudDone)
                    begin
                        txState  <= TxData;
                        bitCount <= '0;
                        uartTxd  <= shiftReg[0];
                    end
                end
                TxData:
                begin
                    if (baudDone)
                    begin
                        if (bitCount == 3'd7)
                        begin
                            // Stop bit
                            txState <= TxStop;
                            uartTxd <= 1'b1;
                        end
                        else
                        begin
                            bitCount <= bitCount + 1'b1;
                            uartTxd  <= shiftReg[0];
                        end
                    end
                end
                TxStop:
                begin
                    if (baudDone)
                        txState <= TxIdle;
                end
                default:
                begin
                    txState <= TxIdle;
                    uartTxd <= 1'b1;
                end
            endcase
        end
    end

    // Shift register, loaded on an accepted write
    always_ff @(posedge pll_clk)
    begin
        if (txState == TxIdle && uartWrite)
            shiftReg <= uartData;
        else if ((txState == TxStart || txState == TxData) && baudDone)
            shiftReg <= shiftReg >> 1;
    end

    // Busy for the whole frame, start through stop
    assign uartBusy = (txState != TxIdle);

endmodule

// ==== files.f ====
design/hostPkg.sv
design/cpuClockDivider.sv
design/boardControl.sv
design/hostBusDecoder.sv
design/hostRam.sv
design/uartIo.sv
design/hostBoard.sv
sim/hostBoardTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile the host board testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=hostBoardSim
LOG_FILE=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    -f files.f \
    --top-module hostBoardTb \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
SIM_STATUS=$?
cat "$LOG_FILE"
if [ $SIM_STATUS -ne 0 ]; then
    echo "Simulation exited with status $SIM_STATUS"
    exit 1
fi

if grep -q "^All tests passed$" "$LOG_FILE"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// ==== sim/hostBoardTb.sv ====
// Host board testbench
`timescale 1ns/1ps

module hostBoardTb;

    import hostPkg::*;

    localparam int    CpuDiv     = 8;
    localparam int    BaudDiv    = 8;
    localparam data_t IntVec     = 8'hC9;
    // Expected bytes from the memory and IO map
    localparam data_t HaltByte   = 8'h76;
    localparam data_t DataPort   = 8'h00;
    localparam data_t StatusPort = 8'h02;
    localparam int    FrameLen   = 10 * BaudDiv;

    typedef enum logic [3:0] {
        OpIdle,
        OpMemWrite,
        OpMemRead,
        OpIoRead,
        OpFrame,
        OpFrameOverlap,
        OpIntKey,
        OpNmiKey,
        OpClock,
        OpHoldPll,
        OpHoldKey
    } opKind_t;

    // One table row
    // Data doubles as a cycle count for key and hold rows
    typedef struct packed {
        opKind_t op;
        addr_t   addr;
        data_t   data;
        data_t   expected;
    } tableEntry_t;

    logic    pll_clk;
    logic    reset;
    logic    pllLocked;
    logic    resetKey;
    logic    intKey;
    logic    nmiKey;
    logic    busStrobe;
    cpuBus_t bus;
    data_t   readData;
    logic    readValid;
    logic    cpuClk;
    logic    intRequest;
    logic    nmiRequest;
    logic    uartTxd;

    // Levels applied to the board inputs on the next rising edge
    logic    intKeyDrive;
    logic    nmiKeyDrive;
    logic    pllLockedDrive;
    logic    resetKeyDrive;

    // Read issued by the previous step and checked one cycle later
    logic    pendingRead;
    data_t   pendingData;

    tableEntry_t testTable[$];
    data_t       shadowMem[int];
    int          errorCount;
    int          cycleCount;
    int          cycleLimit;
    int unsigned seedValue;

    hostBoard #(
        .CpuClockDivide (CpuDiv),
        .BaudDivide     (BaudDiv),
        .IntVector      (IntVec)
    ) dut_i (
        .pll_clk    (pll_clk),
        .reset      (reset),
        .pllLocked  (pllLocked),
        .resetKey   (resetKey),
        .intKey     (intKey),
        .nmiKey     (nmiKey),
        .busStrobe  (busStrobe),
        .bus        (bus),
        .readData   (readData),
        .readValid  (readValid),
        .cpuClk     (cpuClk),
        .intRequest (intRequest),
        .nmiRequest (nmiRequest),
        .uartTxd    (uartTxd)
    );

    // 10 ns clock
    always #5 pll_clk = ~pll_clk;

    // Run limit that grows once the table is known
    always @(posedge pll_clk)
    begin
        cycleCount++;
        if (cycleCount >= cycleLimit)
        begin
            $display("Timeout after %0d cycles, run did not finish", cycleCount);
            $display("Some tests failed");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic checkData(input string name, input data_t actual, input data_t expected);
        if (actual !== expected)
        begin
            errorCount++;
            $display("Fail at %0t: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic checkBit(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            errorCount++;
            $display("Fail at %0t: %s = %b, expected %b", $time, name, actual, expected);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus cycles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic cpuBus_t makeBus(input logic isIo, input logic isWrite,
                                        input addr_t addr, input data_t data);
        cpuBus_t result;
        result.addr      = addr;
        result.writeData = data;
        result.mreq      = ~isIo;
        result.iorq      = isIo;
        result.rd        = ~isWrite;
        result.wr        = isWrite;
        return result;
    endfunction

    // Port number on the upper address byte
    function automatic addr_t portAddr(input data_t port);
        return {port, 8'h00};
    endfunction

    // One pll_clk cycle driven on the rising edge and checked on the falling edge
    task automatic step(input logic strobe, input cpuBus_t busValue,
                        input logic expectRead, input data_t expectData);
        @(posedge pll_clk);
        busStrobe <= strobe;
        bus       <= busValue;
        intKey    <= intKeyDrive;
        nmiKey    <= nmiKeyDrive;
        pllLocked <= pllLockedDrive;
        resetKey  <= resetKeyDrive;
        @(negedge pll_clk);
        // Read data is due exactly one cycle after its strobe
        checkBit("readValid", readValid, pendingRead);
        if (pendingRead)
            checkData("readData", readData, pendingData);
        pendingRead = expectRead;
        pendingData = expectData;
    endtask

    task automatic idleStep();
        step(1'b0, '0, 1'b0, 8'h00);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Table building
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic pushRow(input opKind_t op, input addr_t addr, input data_t data,
                           input data_t expected);
        tableEntry_t entry;
        entry.op       = op;
        entry.addr     = addr;
        entry.data     = data;
        entry.expected = expected;
        testTable.push_back(entry);
    endtask

    // Only the region at 0000-3FFF stores anything
    task automatic memWriteRow(input addr_t addr);
        data_t value;
        value = data_t'($urandom());
        if (addr[15:14] == 2'b00)
            shadowMem[int'(addr[13:0])] = value;
        pushRow(OpMemWrite, addr, value, 8'h00);
    endtask

    task automatic memReadRow(input addr_t addr);
        data_t expected;
        if (addr[15:14] == 2'b00)
            expected = shadowMem[int'(addr[13:0])];
        else
            expected = HaltByte;
        pushRow(OpMemRead, addr, 8'h00, expected);
    endtask

    // Status port reads are placed only where the UART is idle
    task automatic ioReadRow(input data_t port);
        pushRow(OpIoRead, portAddr(port), 8'h00, (port == StatusPort) ? 8'h00 : IntVec);
    endtask

    task automatic buildTable();
        pushRow(OpIdle, 16'h0000, 8'h00, 8'h00);
        pushRow(OpIdle, 16'h0000, 8'h00, 8'h00);
        // RAM edges and a few inner addresses
        memWriteRow(16'h0000);
        memWriteRow(16'h3FFF);
        memWriteRow(16'h0001);
        memWriteRow(16'h1234);
        memWriteRow(16'h2ABC);
        memWriteRow(16'h3FFE);
        // Back to back read-back
        memReadRow(16'h3FFF);
        memReadRow(16'h0000);
        memReadRow(16'h1234);
        memReadRow(16'h0001);
        memReadRow(16'h3FFE);
        memReadRow(16'h2ABC);
        pushRow(OpIdle, 16'h0000, 8'h00, 8'h00);
        // Unmapped space aliasing 0000 and 3FFF
        memWriteRow(16'h4000);
        memWriteRow(16'h8000);
        memWriteRow(16'hFFFF);
        memReadRow(16'h4000);
        memReadRow(16'h8000);
        memReadRow(16'hFFFF);
        memReadRow(16'h0000);
        memReadRow(16'h3FFF);
        // IO map
        ioReadRow(StatusPort);
        ioReadRow(8'h01);
        ioReadRow(8'h03);
        ioReadRow(8'hFF);
        ioReadRow(DataPort);
        // Serial frames
        pushRow(OpFrame, portAddr(DataPort), 8'hA5, 8'h00);
        pushRow(OpFrameOverlap, portAddr(DataPort), data_t'($urandom()), 8'h00);
        ioReadRow(StatusPort);
        // Keys, clock and reset sources
        pushRow(OpIntKey, 16'h0000, 8'd10, 8'h00);
        pushRow(OpNmiKey, 16'h0000, 8'd12, 8'h00);
        pushRow(OpClock, 16'h0000, 8'd24, 8'h00);
        pushRow(OpHoldPll, 16'h0000, 8'd8, 8'h00);
        ioReadRow(StatusPort);
        pushRow(OpHoldKey, 16'h0000, 8'd8, 8'h00);
        memReadRow(16'h1234);
        ioReadRow(StatusPort);
        pushRow(OpIdle, 16'h0000, 8'h00, 8'h00);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Scenario tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // UART frame with the status polled every cycle and txd sampled mid-bit
    task automatic sendFrame(input data_t value, input logic overlap);
        int    lastStep;
        int    bitIndex;
        logic  busyNow;
        logic  expectBit;
        lastStep = overlap ? (2 * FrameLen + 1) : (FrameLen + 1);
        step(1'b1, makeBus(1'b1, 1'b1, portAddr(DataPort), value), 1'b0, 8'h00);
        for (int j = 1; j <= lastStep; j++)
        begin
            // Busy as seen by a strobe in step j
            busyNow = (j <= FrameLen);
            if (overlap && j == FrameLen / 2)
                step(1'b1, makeBus(1'b1, 1'b1, portAddr(DataPort), ~value), 1'b0, 8'h00);
            else
                step(1'b1, makeBus(1'b1, 1'b0, portAddr(StatusPort), 8'h00), 1'b1,
                     {7'b0000000, busyNow});
            if (j > FrameLen)
                checkBit("uartTxd", uartTxd, 1'b1);
            else if (j % BaudDiv == BaudDiv / 2 + 1)
            begin
                bitIndex = j / BaudDiv;
                // Start low, data LSB first, stop high
                if (bitIndex == 0)
                    expectBit = 1'b0;
                else if (bitIndex == 9)
                    expectBit = 1'b1;
                else
                    expectBit = value[bitIndex-1];
                checkBit("uartTxd", uartTxd, expectBit);
            end
        end
    endtask

    // INT follows the key level two cycles late
    task automatic intKeyHold(input int holdCycles);
        intKeyDrive = 1'b0;
        for (int j = 0; j < holdCycles; j++)
        begin
            idleStep();
            checkBit("intRequest", intRequest, j >= 2);
        end
        intKeyDrive = 1'b1;
        for (int j = 0; j < 4; j++)
        begin
            idleStep();
            checkBit("intRequest", intRequest, j < 2);
        end
    endtask

    // One NMI pulse per falling edge and none on release
    task automatic nmiKeyEdge(input int holdCycles);
        nmiKeyDrive = 1'b0;
        for (int j = 0; j < holdCycles; j++)
        begin
            idleStep();
            checkBit("nmiRequest", nmiRequest, j == 3);
        end
        nmiKeyDrive = 1'b1;
        for (int j = 0; j < 5; j++)
        begin
            idleStep();
            checkBit("nmiRequest", nmiRequest, 1'b0);
        end
    endtask

    // Phase locks to the first rising edge and every later cycle is checked
    task automatic cpuClkPeriod(input int cycles);
        int   riseStep;
        logic prevClk;
        riseStep = -1;
        prevClk  = cpuClk;
        for (int j = 0; j < cycles; j++)
        begin
            idleStep();
            if (riseStep < 0)
            begin
                if (!prevClk && cpuClk)
                    riseStep = j;
            end
            else
                checkBit("cpuClk", cpuClk, ((j - riseStep) % CpuDiv) < (CpuDiv / 2));
            prevClk = cpuClk;
        end
        if (riseStep < 0)
        begin
            errorCount++;
            $display("cpuClk never rose during the clock check");
        end
    endtask

    // Board held in reset by a low pllLocked or resetKey
    task automatic resetHold(input logic fromPll, input int cycles);
        cpuBus_t holdBus;
        if (fromPll)
            pllLockedDrive = 1'b0;
        else
            resetKeyDrive = 1'b0;
        idleStep();
        for (int j = 1; j <= cycles; j++)
        begin
            case (j % 3)
                0: holdBus = makeBus(1'b0, 1'b0, 16'h0000, 8'h00);
                1: holdBus = makeBus(1'b1, 1'b0, portAddr(StatusPort), 8'h00);
                default: holdBus = makeBus(1'b1, 1'b1, portAddr(DataPort), 8'h3C);
            endcase
            step(1'b1, holdBus, 1'b0, 8'h00);
            checkBit("uartTxd", uartTxd, 1'b1);
        end
        pllLockedDrive = 1'b1;
        resetKeyDrive  = 1'b1;
        for (int j = 0; j < 3; j++)
        begin
            idleStep();
            checkBit("uartTxd", uartTxd, 1'b1);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial
    begin
        pll_clk        = 1'b0;
        reset          = 1'b1;
        pllLocked      = 1'b1;
        resetKey       = 1'b1;
        intKey         = 1'b1;
        nmiKey         = 1'b1;
        busStrobe      = 1'b0;
        bus            = '0;
        intKeyDrive    = 1'b1;
        nmiKeyDrive    = 1'b1;
        pllLockedDrive = 1'b1;
        resetKeyDrive  = 1'b1;
        pendingRead    = 1'b0;
        pendingData    = 8'h00;
        errorCount     = 0;
        cycleCount     = 0;
        cycleLimit     = 500;
        seedValue      = $urandom(32'h68a0);

        buildTable();
        cycleLimit = testTable.size() * 12 * BaudDiv + 500;

        // Idle state of every output during the four reset cycles
        repeat (3) @(posedge pll_clk);
        @(negedge pll_clk);
        checkBit("readValid", readValid, 1'b0);
        checkBit("intRequest", intRequest, 1'b0);
        checkBit("nmiRequest", nmiRequest, 1'b0);
        checkBit("uartTxd", uartTxd, 1'b1);
        checkBit("cpuClk", cpuClk, 1'b0);
        @(posedge pll_clk);
        reset <= 1'b0;

        foreach (testTable[i])
        begin
            case (testTable[i].op)
                OpMemWrite:
                    step(1'b1, makeBus(1'b0, 1'b1, testTable[i].addr, testTable[i].data),
                         1'b0, 8'h00);
                OpMemRead:
                    step(1'b1, makeBus(1'b0, 1'b0, testTable[i].addr, 8'h00),
                         1'b1, testTable[i].expected);
                OpIoRead:
                    step(1'b1, makeBus(1'b1, 1'b0, testTable[i].addr, 8'h00),
                         1'b1, testTable[i].expected);
                OpFrame:
                    sendFrame(testTable[i].data, 1'b0);
                OpFrameOverlap:
                    sendFrame(testTable[i].data, 1'b1);
                OpIntKey:
                    intKeyHold(int'(testTable[i].data));
                OpNmiKey:
                    nmiKeyEdge(int'(testTable[i].data));
                OpClock:
                    cpuClkPeriod(int'(testTable[i].data));
                OpHoldPll:
                    resetHold(1'b1, int'(testTable[i].data));
                OpHoldKey:
                    resetHold(1'b0, int'(testTable[i].data));
                default:
                    idleStep();
            endcase
        end
        // Flush the last pending read
        idleStep();

        $display("Run finished with %0d errors in %0d cycles", errorCount, cycleCount);
        if (errorCount == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule
